// ==== rtl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and instruction word
`define CPU_DATA_WIDTH 16
// instruction and data memory addresses
`define CPU_ADDR_WIDTH 8
`define CPU_REG_COUNT 8
`define CPU_OPCODE_WIDTH 5

`endif

// ==== rtl/isaPkg.sv ====
`include "cpu_cfg.svh"

package isaPkg;

  typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
  typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIndex_t;

  // any opcode not listed runs as NOP
  typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
    NOP   = 5'b00000,
    HALT  = 5'b00001,
    LOAD  = 5'b00010,
    STORE = 5'b00011,
    SLL   = 5'b00100,
    SLA   = 5'b00101,
    SRL   = 5'b00110,
    SRA   = 5'b00111,
    ADD   = 5'b01000,
    ADDI  = 5'b01001,
    AND   = 5'b01101,
    OR    = 5'b01110,
    XOR   = 5'b01111,
    LDIH  = 5'b10000,
    SUB   = 5'b10010,
    SUBI  = 5'b10011
  } opcode_e;

  typedef union packed {
    struct packed {
      opcode_e   opcode;
      regIndex_t dest;
      logic      spare1;
      regIndex_t src1;
      logic      spare2;
      regIndex_t src2;
    } rForm;
    struct packed {
      opcode_e   opcode;
      regIndex_t dest;
      logic      spare;
      regIndex_t base;   // also first source of shifts
      logic [3:0] offset; // or shift amount
    } riForm;
    struct packed {
      opcode_e    opcode;
      regIndex_t  dest;
      logic [7:0] imm;
    } iForm;
  } instr_u;

  // true for every opcode that ends with a register write
  function automatic logic writesReg(input opcode_e op);
    case (op)
      LOAD, ADD, SUB, AND, OR, XOR, ADDI, SUBI, LDIH: return 1'b1;
      SLL, SRL, SLA, SRA: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// ==== rtl/pipePkg.sv ====
package pipePkg;

  typedef enum logic {
    IDLE = 1'b0,
    EXEC = 1'b1
  } runState_e;

  // which register operands an instruction reads
  typedef enum logic [1:0] {
    NONE = 2'd0,
    RR   = 2'd1, // two registers including STORE
    BASE = 2'd2, // bits 6:4 only
    DEST = 2'd3  // destination field of ADDI/SUBI/LDIH
  } srcClass_e;

endpackage

// ==== rtl/runControl.sv ====
`timescale 1ns/10ps

module runControl (
  input  logic clock,
  input  logic reset,
  input  logic enable,
  input  logic start,
  input  logic haltRetired,
  output logic run
);

  pipePkg::runState_e state;
  pipePkg::runState_e nextState;

  always_comb begin
    nextState = state;
    case (state)
      pipePkg::IDLE: begin
        if (start && enable) begin
          nextState = pipePkg::EXEC;
        end
      end
      pipePkg::EXEC: begin
        if (!enable || haltRetired) begin
          nextState = pipePkg::IDLE;
        end
      end
      default: nextState = pipePkg::IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= pipePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign run = (state == pipePkg::EXEC);

  // run only comes up on a sampled start
  runNeedsStart: assert property (@(posedge clock) disable iff (!reset)
    $rose(run) |-> $past(start));

endmodule

// ==== rtl/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
  input  logic            clock,
  input  logic            reset,
  input  logic            run,
  input  logic            stall,
  input  isaPkg::word_t   iDataIn,
  output isaPkg::addr_t   iAddr,
  output isaPkg::instr_u  idInstr
);

  isaPkg::addr_t pc;

  assign iAddr = pc;

  ////////////////////////////////////////
  // pc and fetch/decode latch
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      pc      <= '0;
      idInstr <= '0; // NOP
    end else if (run && !stall) begin
      pc      <= pc + 1'b1;
      idInstr <= iDataIn;
    end
  end

  // load-use bubble keeps the same fetch address
  stallHoldsPc: assert property (@(posedge clock) disable iff (!reset)
    stall |=> $stable(iAddr));

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module registerFile (
  input  logic               clock,
  input  logic               reset,
  input  isaPkg::regIndex_t  readA,
  input  isaPkg::regIndex_t  readB,
  input  isaPkg::regIndex_t  readC,
  output isaPkg::word_t      valueA,
  output isaPkg::word_t      valueB,
  output isaPkg::word_t      valueC,
  input  logic               writeEnable,
  input  isaPkg::regIndex_t  writeIndex,
  input  isaPkg::word_t      writeValue,
  input  isaPkg::regIndex_t  ySelect,
  output isaPkg::word_t      y
);

  isaPkg::word_t regs [`CPU_REG_COUNT];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeIndex] <= writeValue;
    end
  end

  // old value during a write as decode forwards the new one
  assign valueA = regs[readA];
  assign valueB = regs[readB];
  assign valueC = regs[readC];
  assign y      = regs[ySelect]; // debug port

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  input  isaPkg::instr_u     idInstr,
  input  logic               exWrites,
  input  logic               exIsLoad,
  input  isaPkg::regIndex_t  exDest,
  input  isaPkg::word_t      exResult,
  input  logic               memWrites,
  input  isaPkg::regIndex_t  memDest,
  input  isaPkg::word_t      memValue,
  input  logic               wbWrites,
  input  isaPkg::regIndex_t  wbDest,
  input  isaPkg::word_t      wbValue,
  output isaPkg::regIndex_t  readA,
  output isaPkg::regIndex_t  readB,
  output isaPkg::regIndex_t  readC,
  input  isaPkg::word_t      valueA,
  input  isaPkg::word_t      valueB,
  input  isaPkg::word_t      valueC,
  output logic               stall,
  output isaPkg::instr_u     exInstr,
  output isaPkg::word_t      opA,
  output isaPkg::word_t      opB,
  output isaPkg::word_t      storeData
);

  isaPkg::opcode_e    op;
  pipePkg::srcClass_e srcClass;
  logic               isStore;
  logic               useA;
  logic               useB;
  logic               useC;
  isaPkg::word_t      fwdA;
  isaPkg::word_t      fwdB;
  isaPkg::word_t      fwdC;
  isaPkg::word_t      opBNext;

  // youngest producer wins
  function automatic isaPkg::word_t forward(input isaPkg::regIndex_t idx,
                                            input isaPkg::word_t rfValue);
    isaPkg::word_t value;
    if (exWrites && exDest == idx) begin
      value = exResult;
    end else if (memWrites && memDest == idx) begin
      value = memValue;
    end else if (wbWrites && wbDest == idx) begin
      value = wbValue;
    end else begin
      value = rfValue;
    end
    return value;
  endfunction

  assign op      = idInstr.rForm.opcode;
  assign isStore = (op == isaPkg::STORE);

  always_comb begin
    case (op)
      isaPkg::ADD, isaPkg::SUB, isaPkg::AND, isaPkg::OR, isaPkg::XOR,
      isaPkg::STORE: srcClass = pipePkg::RR;
      isaPkg::LOAD, isaPkg::SLL, isaPkg::SRL, isaPkg::SLA,
      isaPkg::SRA: srcClass = pipePkg::BASE;
      isaPkg::ADDI, isaPkg::SUBI, isaPkg::LDIH: srcClass = pipePkg::DEST;
      default: srcClass = pipePkg::NONE;
    endcase
  end

  assign readA = (srcClass == pipePkg::DEST) ? idInstr.iForm.dest : idInstr.rForm.src1;
  assign readB = idInstr.rForm.src2;
  assign readC = idInstr.rForm.dest; // store data

  assign useA = (srcClass != pipePkg::NONE);
  assign useB = (srcClass == pipePkg::RR) && !isStore;
  assign useC = isStore;

  // LOAD in execute has no data yet
  assign stall = exIsLoad && ((useA && readA == exDest) ||
                              (useB && readB == exDest) ||
                              (useC && readC == exDest));

  always_comb begin
    fwdA = forward(readA, valueA);
    fwdB = forward(readB, valueB);
    fwdC = forward(readC, valueC);
  end

  always_comb begin
    case (srcClass)
      pipePkg::RR:   opBNext = isStore ? isaPkg::word_t'(idInstr.riForm.offset) : fwdB;
      pipePkg::BASE: opBNext = isaPkg::word_t'(idInstr.riForm.offset);
      pipePkg::DEST: begin
        if (op == isaPkg::LDIH) begin
          opBNext = {idInstr.iForm.imm, 8'h00}; // high byte
        end else begin
          opBNext = isaPkg::word_t'(idInstr.iForm.imm);
        end
      end
      default:       opBNext = '0;
    endcase
  end

  ////////////////////////////////////////
  // decode/execute latch
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      exInstr <= '0;
    end else if (run) begin
      exInstr <= stall ? '0 : idInstr; // bubble is a NOP
    end
  end

  always_ff @(posedge clock) begin
    if (run) begin
      opA       <= fwdA;
      opB       <= opBNext;
      storeData <= fwdC;
    end
  end

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  input  isaPkg::instr_u     exInstr,
  input  isaPkg::word_t      opA,
  input  isaPkg::word_t      opB,
  input  isaPkg::word_t      storeData,
  output logic               exWrites,
  output logic               exIsLoad,
  output isaPkg::regIndex_t  exDest,
  output isaPkg::word_t      exResult,
  output isaPkg::instr_u     memInstr,
  output isaPkg::word_t      memResult,
  output isaPkg::addr_t      dAddr,
  output isaPkg::word_t      dDataOut,
  output logic               dWE
);

  isaPkg::opcode_e op;
  logic [3:0]      shamt;

  assign op    = exInstr.rForm.opcode;
  assign shamt = opB[3:0];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (op)
      isaPkg::ADD, isaPkg::ADDI, isaPkg::LDIH,
      isaPkg::LOAD, isaPkg::STORE: exResult = opA + opB; // address for LOAD/STORE
      isaPkg::SUB, isaPkg::SUBI:   exResult = opA - opB;
      isaPkg::AND:                 exResult = opA & opB;
      isaPkg::OR:                  exResult = opA | opB;
      isaPkg::XOR:                 exResult = opA ^ opB;
      isaPkg::SLL, isaPkg::SLA:    exResult = opA << shamt;
      isaPkg::SRL:                 exResult = opA >> shamt;
      isaPkg::SRA:                 exResult = $signed(opA) >>> shamt;
      default:                     exResult = '0;
    endcase
  end

  assign exWrites = isaPkg::writesReg(op);
  assign exIsLoad = (op == isaPkg::LOAD);
  assign exDest   = exInstr.rForm.dest;

  ////////////////////////////////////////
  // execute/memory latch
  ////////////////////////////////////////

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      memInstr <= '0;
      dWE      <= 1'b0;
    end else if (run) begin
      memInstr <= exInstr;
      dWE      <= (op == isaPkg::STORE);
    end else begin
      dWE <= 1'b0; // one write per STORE even when frozen
    end
  end

  always_ff @(posedge clock) begin
    if (run) begin
      memResult <= exResult;
      dDataOut  <= storeData;
    end
  end

  assign dAddr = isaPkg::addr_t'(memResult);

  // write strobe belongs to the STORE in the memory stage
  weIsStore: assert property (@(posedge clock) disable iff (!reset)
    dWE |-> memInstr.rForm.opcode == isaPkg::STORE);

endmodule

// ==== rtl/memWriteback.sv ====
`timescale 1ns/10ps

module memWriteback (
  input  logic               clock,
  input  logic               reset,
  input  logic               run,
  input  isaPkg::instr_u     memInstr,
  input  isaPkg::word_t      memResult,
  input  isaPkg::word_t      dDataIn,
  output logic               memWrites,
  output isaPkg::regIndex_t  memDest,
  output isaPkg::word_t      memValue,
  output logic               wbWrites,
  output isaPkg::regIndex_t  wbDest,
  output isaPkg::word_t      wbValue,
  output logic               haltRetired
);

  isaPkg::opcode_e memOp;
  isaPkg::instr_u  wbInstr;

  assign memOp     = memInstr.rForm.opcode;
  assign memWrites = isaPkg::writesReg(memOp);
  assign memDest   = memInstr.rForm.dest;
  assign memValue  = (memOp == isaPkg::LOAD) ? dDataIn : memResult; // load data

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      wbInstr <= '0;
    end else if (run) begin
      wbInstr <= memInstr;
    end
  end

  always_ff @(posedge clock) begin
    if (run) begin
      wbValue <= memValue;
    end
  end

  // no register write while frozen
  assign wbWrites    = run && isaPkg::writesReg(wbInstr.rForm.opcode);
  assign wbDest      = wbInstr.rForm.dest;
  assign haltRetired = (wbInstr.rForm.opcode == isaPkg::HALT);

endmodule

// ==== rtl/cpuTop.sv ====
`timescale 1ns/10ps

module cpuTop (
  input  logic               clock,
  input  logic               reset,
  input  logic               enable,
  input  logic               start,
  input  isaPkg::word_t      iDataIn,
  input  isaPkg::word_t      dDataIn,
  input  isaPkg::regIndex_t  ySelect,
  output isaPkg::addr_t      iAddr,
  output isaPkg::addr_t      dAddr,
  output isaPkg::word_t      dDataOut,
  output logic               dWE,
  output isaPkg::word_t      y,
  output logic               busy
);

  logic               stall;
  logic               haltRetired;
  isaPkg::instr_u     idInstr;
  isaPkg::instr_u     exInstr;
  isaPkg::instr_u     memInstr;
  isaPkg::word_t      opA;
  isaPkg::word_t      opB;
  isaPkg::word_t      storeData;
  logic               exWrites;
  logic               exIsLoad;
  isaPkg::regIndex_t  exDest;
  isaPkg::word_t      exResult;
  isaPkg::word_t      memResult;
  logic               memWrites;
  isaPkg::regIndex_t  memDest;
  isaPkg::word_t      memValue;
  logic               wbWrites;
  isaPkg::regIndex_t  wbDest;
  isaPkg::word_t      wbValue;
  isaPkg::regIndex_t  readA;
  isaPkg::regIndex_t  readB;
  isaPkg::regIndex_t  readC;
  isaPkg::word_t      valueA;
  isaPkg::word_t      valueB;
  isaPkg::word_t      valueC;

  // busy is the run level that steers every stage
  runControl runControl_i (
    .clock(clock), .reset(reset), .enable(enable), .start(start),
    .haltRetired(haltRetired), .run(busy)
  );

  fetchStage fetchStage_i (
    .clock(clock), .reset(reset), .run(busy), .stall(stall),
    .iDataIn(iDataIn), .iAddr(iAddr), .idInstr(idInstr)
  );

  registerFile registerFile_i (
    .clock(clock), .reset(reset),
    .readA(readA), .readB(readB), .readC(readC),
    .valueA(valueA), .valueB(valueB), .valueC(valueC),
    .writeEnable(wbWrites), .writeIndex(wbDest), .writeValue(wbValue),
    .ySelect(ySelect), .y(y)
  );

  decodeStage decodeStage_i (
    .clock(clock), .reset(reset), .run(busy), .idInstr(idInstr),
    .exWrites(exWrites), .exIsLoad(exIsLoad), .exDest(exDest), .exResult(exResult),
    .memWrites(memWrites), .memDest(memDest), .memValue(memValue),
    .wbWrites(wbWrites), .wbDest(wbDest), .wbValue(wbValue),
    .readA(readA), .readB(readB), .readC(readC),
    .valueA(valueA), .valueB(valueB), .valueC(valueC),
    .stall(stall), .exInstr(exInstr), .opA(opA), .opB(opB), .storeData(storeData)
  );

  executeStage executeStage_i (
    .clock(clock), .reset(reset), .run(busy), .exInstr(exInstr),
    .opA(opA), .opB(opB), .storeData(storeData),
    .exWrites(exWrites), .exIsLoad(exIsLoad), .exDest(exDest), .exResult(exResult),
    .memInstr(memInstr), .memResult(memResult),
    .dAddr(dAddr), .dDataOut(dDataOut), .dWE(dWE)
  );

  memWriteback memWriteback_i (
    .clock(clock), .reset(reset), .run(busy), .memInstr(memInstr),
    .memResult(memResult), .dDataIn(dDataIn),
    .memWrites(memWrites), .memDest(memDest), .memValue(memValue),
    .wbWrites(wbWrites), .wbDest(wbDest), .wbValue(wbValue),
    .haltRetired(haltRetired)
  );

endmodule

// ==== verif/cpuTbProgram.svh ====
`ifndef CPU_TB_PROGRAM_SVH
`define CPU_TB_PROGRAM_SVH

localparam int NumExpects = 11;
localparam int NumStores  = 2;

// final state after HALT
// columns are isMem, register index or memory address and value
expect_t expectTable [NumExpects] = '{
  {1'b0, 8'd0, 16'h8000},
  {1'b0, 8'd1, 16'h00C0},
  {1'b0, 8'd2, 16'h001B},
  {1'b0, 8'd3, 16'h2F40},
  {1'b0, 8'd4, 16'h002F},
  {1'b0, 8'd5, 16'hF000},
  {1'b0, 8'd6, 16'h00BC},
  {1'b0, 8'd7, 16'hE000},
  {1'b1, 8'h20, 16'hF000},
  {1'b1, 8'h2A, 16'h00BC},
  {1'b1, 8'h21, 16'hDE21}  // untouched fill pattern
};

// STOREs in program order as address and data
storeReq_t storeTable [NumStores] = '{
  {8'h20, 16'hF000},
  {8'h2A, 16'h00BC}
};

task automatic loadImage();
  instrMem[0]  = iInstr(isaPkg::LDIH, 3'd1, 8'h12);       // r1 = 1200
  instrMem[1]  = iInstr(isaPkg::ADDI, 3'd1, 8'h34);       // r1 = 1234
  instrMem[2]  = iInstr(isaPkg::ADDI, 3'd2, 8'h20);       // r2 = 0020
  instrMem[3]  = riInstr(isaPkg::LOAD, 3'd3, 3'd2, 4'h0); // r3 = 00f0
  instrMem[4]  = rInstr(isaPkg::ADD, 3'd4, 3'd3, 3'd1);   // r4 = 1324 after a bubble
  instrMem[5]  = rInstr(isaPkg::SUB, 3'd5, 3'd4, 3'd3);   // r5 = 1234
  instrMem[6]  = rInstr(isaPkg::AND, 3'd6, 3'd5, 3'd4);   // r6 = 1224
  instrMem[7]  = rInstr(isaPkg::OR, 3'd7, 3'd6, 3'd3);    // r7 = 12f4
  instrMem[8]  = rInstr(isaPkg::XOR, 3'd1, 3'd7, 3'd5);   // r1 = 00c0
  instrMem[9]  = iInstr(isaPkg::SUBI, 3'd2, 8'h05);       // r2 = 001b
  instrMem[10] = riInstr(isaPkg::SLL, 3'd3, 3'd7, 4'd4);  // r3 = 2f40
  instrMem[11] = riInstr(isaPkg::SRL, 3'd4, 3'd3, 4'd8);  // r4 = 002f
  instrMem[12] = iInstr(isaPkg::LDIH, 3'd0, 8'h80);       // r0 = 8000
  instrMem[13] = riInstr(isaPkg::SRA, 3'd5, 3'd0, 4'd3);  // r5 = f000
  instrMem[14] = riInstr(isaPkg::SLA, 3'd6, 3'd4, 4'd2);  // r6 = 00bc
  instrMem[15] = riInstr(isaPkg::STORE, 3'd5, 3'd2, 4'h5); // mem[20] = r5
  instrMem[16] = riInstr(isaPkg::STORE, 3'd6, 3'd2, 4'hF); // mem[2a] = r6
  instrMem[17] = riInstr(isaPkg::LOAD, 3'd7, 3'd2, 4'h5); // r7 = f000
  instrMem[18] = rInstr(isaPkg::ADD, 3'd7, 3'd7, 3'd7);   // r7 = e000 after a bubble
  instrMem[19] = iInstr(isaPkg::HALT, 3'd0, 8'h00);
  // never retire
  instrMem[20] = iInstr(isaPkg::ADDI, 3'd1, 8'h7F);
  instrMem[21] = iInstr(isaPkg::ADDI, 3'd2, 8'h7F);
  instrMem[22] = iInstr(isaPkg::ADDI, 3'd3, 8'h7F);
  dataMem[8'h20] = 16'h00F0; // load source, later overwritten
endtask

`endif

// ==== verif/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;

  typedef struct packed {
    logic          isMem;
    isaPkg::addr_t where;
    isaPkg::word_t value;
  } expect_t;

  typedef struct packed {
    isaPkg::addr_t addr;
    isaPkg::word_t data;
  } storeReq_t;

  logic               clock;
  logic               reset;
  logic               enable;
  logic               start;
  isaPkg::regIndex_t  ySelect;
  isaPkg::word_t      iDataIn;
  isaPkg::word_t      dDataIn;
  isaPkg::addr_t      iAddr;
  isaPkg::addr_t      dAddr;
  isaPkg::word_t      dDataOut;
  logic               dWE;
  isaPkg::word_t      y;
  logic               busy;

  isaPkg::word_t instrMem [2**$bits(isaPkg::addr_t)];
  isaPkg::word_t dataMem [2**$bits(isaPkg::addr_t)];
  int            storeCount = 0;

  cpuTop cpuTop_i (
    .clock(clock), .reset(reset), .enable(enable), .start(start),
    .iDataIn(iDataIn), .dDataIn(dDataIn), .ySelect(ySelect),
    .iAddr(iAddr), .dAddr(dAddr), .dDataOut(dDataOut), .dWE(dWE),
    .y(y), .busy(busy)
  );

  ////////////////////////////////////////
  // instruction encoding
  ////////////////////////////////////////

  function automatic isaPkg::word_t rInstr(input isaPkg::opcode_e op,
      input isaPkg::regIndex_t dest, input isaPkg::regIndex_t src1,
      input isaPkg::regIndex_t src2);
    isaPkg::instr_u w;
    w = '0;
    w.rForm.opcode = op;
    w.rForm.dest   = dest;
    w.rForm.src1   = src1;
    w.rForm.src2   = src2;
    return w;
  endfunction

  function automatic isaPkg::word_t riInstr(input isaPkg::opcode_e op,
      input isaPkg::regIndex_t dest, input isaPkg::regIndex_t base,
      input logic [3:0] offset);
    isaPkg::instr_u w;
    w = '0;
    w.riForm.opcode = op;
    w.riForm.dest   = dest;
    w.riForm.base   = base;
    w.riForm.offset = offset;
    return w;
  endfunction

  function automatic isaPkg::word_t iInstr(input isaPkg::opcode_e op,
      input isaPkg::regIndex_t dest, input logic [7:0] imm);
    isaPkg::instr_u w;
    w.iForm.opcode = op;
    w.iForm.dest   = dest;
    w.iForm.imm    = imm;
    return w;
  endfunction

  `include "cpuTbProgram.svh"

  ////////////////////////////////////////
  // checks and waits
  ////////////////////////////////////////

  task automatic abortRun(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic checkWord(input isaPkg::word_t got, input isaPkg::word_t want,
                           input string what);
    if (got !== want) begin
      abortRun($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic checkAddr(input isaPkg::addr_t got, input isaPkg::addr_t want,
                           input string what);
    if (got !== want) begin
      abortRun($sformatf("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic checkBit(input logic got, input logic want, input string what);
    if (got !== want) begin
      abortRun($sformatf("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  task automatic waitBusy(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clock);
    while (busy !== level) begin
      n++;
      if (n > limit) begin
        abortRun($sformatf("busy did not go to %0b within %0d cycles", level, limit));
      end else begin
        @(negedge clock);
      end
    end
  endtask

  task automatic waitFetch(input isaPkg::addr_t addr, input int limit);
    int n;
    n = 0;
    @(negedge clock);
    while (iAddr !== addr) begin
      n++;
      if (n > limit) begin
        abortRun($sformatf("fetch never reached address %h within %0d cycles", addr, limit));
      end else begin
        @(negedge clock);
      end
    end
  endtask

  task automatic pulseStart();
    @(posedge clock);
    enable <= 1'b1;
    start  <= 1'b1;
    @(posedge clock);
    start  <= 1'b0;
  endtask

  // memory models
  assign iDataIn = instrMem[iAddr];
  assign dDataIn = dataMem[dAddr];

  always @(posedge clock) begin
    if (dWE === 1'b1) begin
      dataMem[dAddr] <= dDataOut;
    end
  end

  // every write strobe must match the next STORE of the program
  always @(negedge clock) begin
    if (dWE === 1'b1) begin
      if (storeCount >= NumStores) begin
        abortRun("data memory was written more often than the program stores");
      end else begin
        checkAddr(dAddr, storeTable[storeCount].addr, "store address");
        checkWord(dDataOut, storeTable[storeCount].data, "store data");
        storeCount++;
      end
    end
  end

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    reset   = 1'b0;
    enable  = 1'b0;
    start   = 1'b0;
    ySelect = '0;
    for (int i = 0; i < $size(instrMem); i++) begin
      instrMem[i] = isaPkg::word_t'(i); // NOP with the address in its spare bits
      dataMem[i]  = {~i[7:0], i[7:0]};
    end
    loadImage();
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    checkBit(busy, 1'b0, "busy after reset");
    checkBit(dWE, 1'b0, "dWE after reset");
    checkAddr(iAddr, '0, "iAddr after reset");
    for (int r = 0; r < 8; r++) begin
      @(posedge clock);
      ySelect <= isaPkg::regIndex_t'(r);
      @(negedge clock);
      checkWord(y, '0, $sformatf("r%0d after reset", r));
    end

    pulseStart();
    waitBusy(1'b1, 4);
    waitFetch(8'd9, 40); // freeze part way through
    @(posedge clock);
    enable <= 1'b0;
    waitBusy(1'b0, 4);
    checkAddr(iAddr, 8'd11, "iAddr when frozen");
    repeat (4) @(negedge clock);
    checkAddr(iAddr, 8'd11, "iAddr while frozen");

    pulseStart();
    waitBusy(1'b1, 4);
    waitBusy(1'b0, 100); // HALT retires
    checkAddr(iAddr, 8'd24, "iAddr when halted");
    repeat (6) @(negedge clock);
    checkAddr(iAddr, 8'd24, "iAddr after HALT");
    checkBit(dWE, 1'b0, "dWE after HALT");

    for (int k = 0; k < NumExpects; k++) begin
      if (expectTable[k].isMem) begin
        checkWord(dataMem[expectTable[k].where], expectTable[k].value,
                  $sformatf("mem[%h]", expectTable[k].where));
      end else begin
        @(posedge clock);
        ySelect <= isaPkg::regIndex_t'(expectTable[k].where);
        @(negedge clock);
        checkWord(y, expectTable[k].value, $sformatf("r%0d", expectTable[k].where));
      end
    end

    if (storeCount != NumStores) begin
      abortRun($sformatf("expected %0d data memory writes but saw %0d",
                         NumStores, storeCount));
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+rtl
+incdir+verif
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/runControl.sv
rtl/fetchStage.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/cpuTop.sv
verif/cpuTb.sv
